/* game_defs.svh */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// one turn engine per player
`define NUM_PLAYERS 2

// pace divider width, wide enough for the board-rate reload
`define PACE_WIDTH 26

// default reload for the pace divider
// simulation overrides this through the top-level parameter
`define PACE_RELOAD 300000

`endif

/* game_state_pkg.sv */
`default_nettype none

package game_state_pkg;

    // game-level states of the round sequencer
    typedef enum logic [3:0] {
        START,
        MAIN_MENU,
        DRAW_BOARD,
        DRAW_SPIRIT,
        DRAW_GHOST_0,
        DRAW_GHOST_1,
        // wait for the pace divider before the turns
        PACE_WAIT,
        TURN_GRANT,
        TURN_WAIT,
        // spirit caught or not
        SPIRIT_CHECK,
        RAND_SPIRIT,
        END_GAME
    } round_state_t;

endpackage

`default_nettype wire

/* move_pkg.sv */
`default_nettype none

package move_pkg;

    // enum value doubles as the bit index into keys_t
    typedef enum logic [1:0] {
        RIGHT,
        LEFT,
        UP,
        DOWN
    } dir_t;

    // player number
    typedef logic player_idx_t;

    // bit 0 right, bit 1 left, bit 2 up, bit 3 down
    typedef logic [3:0] keys_t;

endpackage

`default_nettype wire

/* player_cmd_if.sv */
`default_nettype none

interface player_cmd_if
    import move_pkg::*;
();
    // requests from the turn engine, held as levels
    logic erase_req;
    logic move_req;
    dir_t dir;
    // completions routed back by the port mux
    logic erase_done;
    logic move_valid;

    modport player (output erase_req, move_req, dir, input erase_done, move_valid);

    modport mux (input erase_req, move_req, dir, output erase_done, move_valid);

endinterface

`default_nettype wire

/* pace_timer.sv */
`default_nettype none
`include "game_defs.svh"

module pace_timer #(
    parameter int unsigned reload = `PACE_RELOAD
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    logic [`PACE_WIDTH-1:0] count;

    // free-running down-counter, reload on zero
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= `PACE_WIDTH'(reload);
        end else if (count == '0) begin
            count <= `PACE_WIDTH'(reload);
        end else begin
            count <= count - 1'b1;
        end
    end

    // one cycle per period
    assign tick = (count == '0);

endmodule

`default_nettype wire

/* round_sequencer.sv */
`default_nettype none
`include "game_defs.svh"

module round_sequencer
    import game_state_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start_game,
    input  logic                    board_done,
    input  logic                    spirit_done,
    input  logic                    ghost_done,
    input  logic                    ghost_done_2,
    input  logic                    pace_tick,
    input  logic                    erase_spirit_done,
    input  logic                    endgame,
    input  logic [`NUM_PLAYERS-1:0] turn_done,
    output logic [`NUM_PLAYERS-1:0] turn_grant,
    output logic                    start,
    output logic                    draw_board,
    output logic                    draw_spirit,
    output logic                    draw_ghost,
    output logic                    draw_ghost_2,
    output logic                    spirit_caught,
    output logic                    rand_spirit,
    output logic                    draw_end
);

    localparam int cnt_w = (`NUM_PLAYERS > 1) ? $clog2(`NUM_PLAYERS) : 1;
    localparam logic [cnt_w-1:0] last_player = cnt_w'(`NUM_PLAYERS - 1);

    round_state_t state;
    round_state_t state_next;
    // whose turn it is
    logic [cnt_w-1:0] player_cnt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= START;
            player_cnt <= '0;
        end else begin
            state <= state_next;
            // step to the next player once the current one finishes
            if (state == TURN_WAIT && turn_done[player_cnt]) begin
                player_cnt <= (player_cnt == last_player) ? '0 : player_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            START:        state_next = MAIN_MENU;
            MAIN_MENU:    if (start_game) state_next = DRAW_BOARD;
            DRAW_BOARD:   if (board_done) state_next = DRAW_SPIRIT;
            DRAW_SPIRIT:  if (spirit_done) state_next = DRAW_GHOST_0;
            DRAW_GHOST_0: if (ghost_done) state_next = DRAW_GHOST_1;
            DRAW_GHOST_1: if (ghost_done_2) state_next = PACE_WAIT;
            PACE_WAIT:    if (pace_tick) state_next = TURN_GRANT;
            // grant is a single cycle
            TURN_GRANT:   state_next = TURN_WAIT;
            TURN_WAIT: begin
                if (turn_done[player_cnt]) begin
                    state_next = (player_cnt == last_player) ? SPIRIT_CHECK : TURN_GRANT;
                end
            end
            // not caught, redraw and play another round
            SPIRIT_CHECK: state_next = erase_spirit_done ? RAND_SPIRIT : DRAW_SPIRIT;
            RAND_SPIRIT:  state_next = endgame ? END_GAME : DRAW_SPIRIT;
            // game over, stay here until reset
            END_GAME:     state_next = END_GAME;
            default:      state_next = START;
        endcase
    end

    // moore outputs, all decoded from state
    always_comb begin
        turn_grant    = '0;
        start         = 1'b0;
        draw_board    = 1'b0;
        draw_spirit   = 1'b0;
        draw_ghost    = 1'b0;
        draw_ghost_2  = 1'b0;
        spirit_caught = 1'b0;
        rand_spirit   = 1'b0;
        draw_end      = 1'b0;
        case (state)
            START:        start = 1'b1;
            DRAW_BOARD:   draw_board = 1'b1;
            DRAW_SPIRIT:  draw_spirit = 1'b1;
            DRAW_GHOST_0: draw_ghost = 1'b1;
            DRAW_GHOST_1: draw_ghost_2 = 1'b1;
            TURN_GRANT:   turn_grant[player_cnt] = 1'b1;
            SPIRIT_CHECK: spirit_caught = 1'b1;
            RAND_SPIRIT:  rand_spirit = 1'b1;
            END_GAME:     draw_end = 1'b1;
            default:      start = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* player_turn.sv */
`default_nettype none

module player_turn
    import move_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  keys_t        keys,
    input  logic         turn_grant,
    output logic         turn_done,
    player_cmd_if.player cmd
);

    typedef enum logic [1:0] {IDLE, ERASE, MOVE, FINISH} turn_state_t;

    turn_state_t state;
    turn_state_t state_next;
    dir_t        key_dir;
    dir_t        dir_q;

    // key priority right, left, up, down
    always_comb begin
        key_dir = DOWN;
        if (keys[RIGHT]) begin
            key_dir = RIGHT;
        end else if (keys[LEFT]) begin
            key_dir = LEFT;
        end else if (keys[UP]) begin
            key_dir = UP;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            // no key pressed, skip the turn
            IDLE:    if (turn_grant) state_next = (|keys) ? ERASE : FINISH;
            ERASE:   if (cmd.erase_done) state_next = MOVE;
            // keep stepping until the tile is valid
            MOVE:    if (cmd.move_valid) state_next = FINISH;
            FINISH:  state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            cmd.erase_req <= 1'b0;
            cmd.move_req  <= 1'b0;
        end else begin
            state <= state_next;
            // requests lag the state by a cycle and drop on their done
            cmd.erase_req <= (state == ERASE) && !cmd.erase_done;
            cmd.move_req  <= (state == MOVE) && !cmd.move_valid;
        end
    end

    // direction held for the whole turn
    always_ff @(posedge clk) begin
        if (state == IDLE && turn_grant) begin
            dir_q <= key_dir;
        end
    end

    assign cmd.dir   = dir_q;
    assign turn_done = (state == FINISH);

endmodule

`default_nettype wire

/* datapath_port_mux.sv */
`default_nettype none
`include "game_defs.svh"

module datapath_port_mux
    import move_pkg::*;
(
    player_cmd_if.mux cmd [`NUM_PLAYERS],
    input  logic      erase_ghost_done,
    input  logic      valid,
    output keys_t     erase_ghost [`NUM_PLAYERS],
    output keys_t     move [`NUM_PLAYERS]
);

    // one strobe bit per direction
    function automatic keys_t dir_onehot(input dir_t d);
        keys_t v;
        v    = '0;
        v[d] = 1'b1;
        return v;
    endfunction

    for (genvar p = 0; p < `NUM_PLAYERS; p++) begin : g_port
        localparam player_idx_t pid = player_idx_t'(p);

        // strobes only while the request is up
        assign erase_ghost[pid] = cmd[p].erase_req ? dir_onehot(cmd[p].dir) : '0;
        assign move[pid]        = cmd[p].move_req ? dir_onehot(cmd[p].dir) : '0;

        // shared done lines go back only to the requester
        assign cmd[p].erase_done = cmd[p].erase_req & erase_ghost_done;
        assign cmd[p].move_valid = cmd[p].move_req & valid;
    end

endmodule

`default_nettype wire

/* game_control.sv */
`default_nettype none
`include "game_defs.svh"

module game_control
    import move_pkg::*;
#(
    parameter int unsigned pace_reload = `PACE_RELOAD
) (
    input  logic clk,
    input  logic reset,
    input  logic go_right,
    input  logic go_left,
    input  logic go_up,
    input  logic go_down,
    input  logic go_right2,
    input  logic go_left2,
    input  logic go_up2,
    input  logic go_down2,
    input  logic start_game,
    input  logic board_done,
    input  logic spirit_done,
    input  logic ghost_done,
    input  logic ghost_done_2,
    input  logic erase_ghost_done,
    input  logic valid,
    input  logic erase_spirit_done,
    input  logic endgame,
    output logic start,
    output logic draw_board,
    output logic draw_spirit,
    output logic draw_ghost,
    output logic draw_ghost_2,
    output logic move_right,
    output logic move_left,
    output logic move_up,
    output logic move_down,
    output logic move_right2,
    output logic move_left2,
    output logic move_up2,
    output logic move_down2,
    output logic erase_ghost_right,
    output logic erase_ghost_left,
    output logic erase_ghost_up,
    output logic erase_ghost_down,
    output logic erase_ghost_right2,
    output logic erase_ghost_left2,
    output logic erase_ghost_up2,
    output logic erase_ghost_down2,
    output logic spirit_caught,
    output logic rand_spirit,
    output logic draw_end
);

    logic                    pace_tick;
    logic [`NUM_PLAYERS-1:0] turn_grant;
    logic [`NUM_PLAYERS-1:0] turn_done;
    keys_t                   player_keys [`NUM_PLAYERS];
    keys_t                   erase_vec [`NUM_PLAYERS];
    keys_t                   move_vec [`NUM_PLAYERS];

    player_cmd_if cmd [`NUM_PLAYERS] ();

    // bit order follows dir_t
    assign player_keys[0] = {go_down, go_up, go_left, go_right};
    assign player_keys[1] = {go_down2, go_up2, go_left2, go_right2};

    pace_timer #(
        .reload(pace_reload)
    ) pace_timer_inst (
        .clk  (clk),
        .reset(reset),
        .tick (pace_tick)
    );

    round_sequencer round_sequencer_inst (
        .clk              (clk),
        .reset            (reset),
        .start_game       (start_game),
        .board_done       (board_done),
        .spirit_done      (spirit_done),
        .ghost_done       (ghost_done),
        .ghost_done_2     (ghost_done_2),
        .pace_tick        (pace_tick),
        .erase_spirit_done(erase_spirit_done),
        .endgame          (endgame),
        .turn_done        (turn_done),
        .turn_grant       (turn_grant),
        .start            (start),
        .draw_board       (draw_board),
        .draw_spirit      (draw_spirit),
        .draw_ghost       (draw_ghost),
        .draw_ghost_2     (draw_ghost_2),
        .spirit_caught    (spirit_caught),
        .rand_spirit      (rand_spirit),
        .draw_end         (draw_end)
    );

    // one turn engine per player
    for (genvar p = 0; p < `NUM_PLAYERS; p++) begin : g_player
        player_turn player_turn_inst (
            .clk       (clk),
            .reset     (reset),
            .keys      (player_keys[p]),
            .turn_grant(turn_grant[p]),
            .turn_done (turn_done[p]),
            .cmd       (cmd[p])
        );
    end

    datapath_port_mux datapath_port_mux_inst (
        .cmd             (cmd),
        .erase_ghost_done(erase_ghost_done),
        .valid           (valid),
        .erase_ghost     (erase_vec),
        .move            (move_vec)
    );

    // player one strobes
    assign erase_ghost_right = erase_vec[0][RIGHT];
    assign erase_ghost_left  = erase_vec[0][LEFT];
    assign erase_ghost_up    = erase_vec[0][UP];
    assign erase_ghost_down  = erase_vec[0][DOWN];
    assign move_right        = move_vec[0][RIGHT];
    assign move_left         = move_vec[0][LEFT];
    assign move_up           = move_vec[0][UP];
    assign move_down         = move_vec[0][DOWN];

    // player two strobes
    assign erase_ghost_right2 = erase_vec[1][RIGHT];
    assign erase_ghost_left2  = erase_vec[1][LEFT];
    assign erase_ghost_up2    = erase_vec[1][UP];
    assign erase_ghost_down2  = erase_vec[1][DOWN];
    assign move_right2        = move_vec[1][RIGHT];
    assign move_left2         = move_vec[1][LEFT];
    assign move_up2           = move_vec[1][UP];
    assign move_down2         = move_vec[1][DOWN];

endmodule

`default_nettype wire

/* game_control_assertions.sv */
`default_nettype none
`include "game_defs.svh"

module game_control_assertions #(
    parameter int excl_width = 2,
    parameter int hold_width = 1
) (
    input logic                  clk,
    input logic                  reset,
    input logic [excl_width-1:0] excl,
    input logic                  hold_en,
    input logic [hold_width-1:0] hold_val,
    input logic                  req,
    input logic                  ack
);
    timeunit 1ns;
    timeprecision 100ps;

    // grants one at a time, erase and move never together
    excl_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(excl))
        else $error("exclusive signals overlap, value %b", excl);

    // game over is final, direction fixed while a request is up
    hold_stable: assert property (
        @(posedge clk) disable iff (reset) hold_en |=> $stable(hold_val)
    ) else $error("held value changed while it had to stay, now %h", hold_val);

    // a level request stays up until its done arrives
    req_until_ack: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
        else $error("request dropped before its done");

endmodule

bind round_sequencer game_control_assertions #(
    .excl_width(`NUM_PLAYERS),
    .hold_width(1)
) seq_checks (
    .clk     (clk),
    .reset   (reset),
    .excl    (turn_grant),
    .hold_en (draw_end),
    .hold_val(draw_end),
    .req     (draw_board | draw_spirit | draw_ghost | draw_ghost_2),
    .ack     (board_done | spirit_done | ghost_done | ghost_done_2)
);

bind player_turn game_control_assertions #(
    .excl_width(2),
    .hold_width(2)
) turn_checks (
    .clk     (clk),
    .reset   (reset),
    .excl    ({cmd.erase_req, cmd.move_req}),
    .hold_en (cmd.erase_req | cmd.move_req),
    .hold_val(cmd.dir),
    .req     (cmd.erase_req | cmd.move_req),
    .ack     (cmd.erase_done | cmd.move_valid)
);

`default_nettype wire

/* game_control_tb.sv */
`default_nettype none

module game_control_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int round_timeout = 400;
    localparam int num_random = 8;
    localparam logic [2:0] no_dir = 3'd4;

    // keys bit 0 right, 1 left, 2 up, 3 down
    // expected dir 0..3 in the same order, 4 for no strobe
    typedef struct packed {
        logic [3:0] keys1;
        logic [3:0] keys2;
        logic       spirit_hit;
        logic       end_game;
        logic [2:0] exp1;
        logic [2:0] exp2;
    } round_row_t;

    round_row_t fixed_rows [5] = '{
        '{4'b0001, 4'b0100, 1'b0, 1'b0, 3'd0, 3'd2},
        '{4'b1010, 4'b0000, 1'b1, 1'b0, 3'd1, 3'd4},
        '{4'b0000, 4'b1000, 1'b0, 1'b0, 3'd4, 3'd3},
        '{4'b1111, 4'b1100, 1'b1, 1'b0, 3'd0, 3'd2},
        '{4'b0000, 4'b0000, 1'b0, 1'b0, 3'd4, 3'd4}
    };
    // game over row, always last
    round_row_t last_row = '{4'b1000, 4'b0010, 1'b1, 1'b1, 3'd3, 3'd1};

    // strobe names by index into obs
    string names [23] = '{
        "draw_board", "draw_spirit", "draw_ghost", "draw_ghost_2",
        "spirit_caught", "rand_spirit", "draw_end",
        "erase_ghost_right", "erase_ghost_left", "erase_ghost_up", "erase_ghost_down",
        "move_right", "move_left", "move_up", "move_down",
        "erase_ghost_right2", "erase_ghost_left2", "erase_ghost_up2", "erase_ghost_down2",
        "move_right2", "move_left2", "move_up2", "move_down2"
    };

    logic clk;
    logic reset;
    logic go_right, go_left, go_up, go_down;
    logic go_right2, go_left2, go_up2, go_down2;
    logic start_game, board_done, spirit_done, ghost_done, ghost_done_2;
    logic erase_ghost_done, valid, erase_spirit_done, endgame;
    logic start, draw_board, draw_spirit, draw_ghost, draw_ghost_2;
    logic move_right, move_left, move_up, move_down;
    logic move_right2, move_left2, move_up2, move_down2;
    logic erase_ghost_right, erase_ghost_left, erase_ghost_up, erase_ghost_down;
    logic erase_ghost_right2, erase_ghost_left2, erase_ghost_up2, erase_ghost_down2;
    logic spirit_caught, rand_spirit, draw_end;

    logic [22:0] obs;
    logic [22:0] obs_prev;
    int          seen [$];
    int          hold_cnt [6] = '{0, 0, 0, 0, 0, 0};
    int          errors;
    int          checks;
    logic        aborted;
    logic        start_may_rise;
    logic [31:0] lcg_state;
    round_row_t  rows [$];

    // bit 0 draw_board up to bit 22 move_down2, same order as names
    assign obs = {move_down2, move_up2, move_left2, move_right2,
                  erase_ghost_down2, erase_ghost_up2, erase_ghost_left2, erase_ghost_right2,
                  move_down, move_up, move_left, move_right,
                  erase_ghost_down, erase_ghost_up, erase_ghost_left, erase_ghost_right,
                  draw_end, rand_spirit, spirit_caught, draw_ghost_2, draw_ghost,
                  draw_spirit, draw_board};

    game_control #(
        .pace_reload(12)
    ) game_control_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // priority right, left, up, down
    function automatic logic [2:0] prio_dir(input logic [3:0] k);
        if (k[0]) return 3'd0;
        if (k[1]) return 3'd1;
        if (k[2]) return 3'd2;
        if (k[3]) return 3'd3;
        return no_dir;
    endfunction

    // one clock, then datapath model, rise log and invariants
    task automatic cycle();
        logic [5:0] req;
        @(posedge clk);
        #5;
        req = {|{obs[22:19], obs[14:11]}, |{obs[18:15], obs[10:7]}, obs[3:0]};
        // done rises on the third cycle of a strobe, clears when it drops
        for (int i = 0; i < 6; i++) begin
            hold_cnt[i] = req[i] ? hold_cnt[i] + 1 : 0;
        end
        board_done       = (hold_cnt[0] >= 3);
        spirit_done      = (hold_cnt[1] >= 3);
        ghost_done       = (hold_cnt[2] >= 3);
        ghost_done_2     = (hold_cnt[3] >= 3);
        erase_ghost_done = (hold_cnt[4] >= 3);
        valid            = (hold_cnt[5] >= 3);
        for (int i = 0; i < 23; i++) begin
            if (obs[i] && !obs_prev[i]) seen.push_back(i);
        end
        checks += 5;
        assert ($onehot0(obs[3:0])) else begin
            errors++;
            $display("error: draw strobes = 'h%h, more than one high", obs[3:0]);
        end
        assert (!(|obs[22:7] && |obs[3:0])) else begin
            errors++;
            $display("error: turn strobes = 'h%h while draw strobes = 'h%h", obs[22:7], obs[3:0]);
        end
        // also covers both players at once
        assert ($onehot0(obs[22:7])) else begin
            errors++;
            $display("error: turn strobes = 'h%h, more than one high", obs[22:7]);
        end
        assert (!obs_prev[6] || obs[6]) else begin
            errors++;
            $display("draw_end fell after the game had ended");
        end
        assert (!start || start_may_rise) else begin
            errors++;
            $display("error: start = 'h%h outside the reset cycle", start);
        end
        obs_prev = obs;
    endtask

    task automatic run_round(input round_row_t row, input int idx, input bit first);
        int exp_q [$];
        int waited;
        {go_down, go_up, go_left, go_right} = row.keys1;
        {go_down2, go_up2, go_left2, go_right2} = row.keys2;
        erase_spirit_done = row.spirit_hit;
        endgame = row.end_game;
        // board and spirit draw only open the first round
        if (first) begin
            exp_q.push_back(0);
            exp_q.push_back(1);
        end
        exp_q.push_back(2);
        exp_q.push_back(3);
        if (row.exp1 != no_dir) begin
            exp_q.push_back(7 + row.exp1);
            exp_q.push_back(11 + row.exp1);
        end
        if (row.exp2 != no_dir) begin
            exp_q.push_back(15 + row.exp2);
            exp_q.push_back(19 + row.exp2);
        end
        exp_q.push_back(4);
        if (row.spirit_hit) exp_q.push_back(5);
        // next draw_spirit or draw_end closes the round
        exp_q.push_back((row.spirit_hit && row.end_game) ? 6 : 1);
        waited = 0;
        while (seen.size() < exp_q.size() && waited < round_timeout) begin
            cycle();
            waited++;
        end
        if (seen.size() < exp_q.size()) begin
            errors++;
            aborted = 1'b1;
            $display("round %0d timed out with %0d of %0d strobes seen",
                     idx, seen.size(), exp_q.size());
        end
        for (int i = 0; i < exp_q.size() && i < seen.size(); i++) begin
            checks++;
            assert (seen[i] == exp_q[i]) else begin
                errors++;
                $display("error: round %0d strobe %0d is %s ('h%0h), expected %s ('h%0h)",
                         idx, i, names[seen[i]], seen[i], names[exp_q[i]], exp_q[i]);
            end
        end
        seen.delete();
    endtask

    initial begin
        round_row_t  row;
        logic [31:0] rnd;
        reset = 1'b1;
        {go_right, go_left, go_up, go_down} = '0;
        {go_right2, go_left2, go_up2, go_down2} = '0;
        {start_game, board_done, spirit_done, ghost_done, ghost_done_2} = '0;
        {erase_ghost_done, valid, erase_spirit_done, endgame} = '0;
        errors = 0;
        checks = 0;
        aborted = 1'b0;
        start_may_rise = 1'b1;
        obs_prev = '0;
        lcg_state = 32'hd795d089;
        foreach (fixed_rows[i]) rows.push_back(fixed_rows[i]);
        // random keys, expected dirs from the priority rule
        for (int i = 0; i < num_random; i++) begin
            rnd = next_random();
            row.keys1 = rnd[31:28];
            row.keys2 = rnd[27:24];
            row.spirit_hit = rnd[20];
            row.end_game = 1'b0;
            row.exp1 = prio_dir(row.keys1);
            row.exp2 = prio_dir(row.keys2);
            rows.push_back(row);
        end
        rows.push_back(last_row);

        repeat (3) cycle();
        reset = 1'b0;
        checks++;
        assert (start && obs == '0) else begin
            errors++;
            $display("error: start = 'h%h, others = 'h%h after reset, expected 'h1 and 'h0",
                     start, obs);
        end
        // start lasts a single cycle
        start_may_rise = 1'b0;
        cycle();
        // menu stays quiet without start_game
        repeat (6) begin
            cycle();
            checks++;
            assert (obs == '0 && seen.size() == 0) else begin
                errors++;
                $display("error: outputs = 'h%h in the main menu, expected 'h0", obs);
            end
        end
        start_game = 1'b1;
        cycle();
        start_game = 1'b0;

        foreach (rows[r]) begin
            if (!aborted) run_round(rows[r], r, r == 0);
        end
        // game over holds with no further strobes
        for (int i = 0; i < 8 && !aborted; i++) begin
            cycle();
            checks++;
            assert (draw_end) else begin
                errors++;
                $display("error: draw_end = 'h%h after game over, expected 'h1", draw_end);
            end
        end
        checks++;
        assert (seen.size() == 0) else begin
            errors++;
            $display("strobes rose after the game ended");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* game_control.f */
+incdir+.
game_state_pkg.sv
move_pkg.sv
player_cmd_if.sv
pace_timer.sv
round_sequencer.sv
player_turn.sv
datapath_port_mux.sv
game_control.sv
game_control_assertions.sv
game_control_tb.sv

/* Bender.yml */
package:
  name: game_control

export_include_dirs:
  - .

sources:
  - files:
      - game_state_pkg.sv
      - move_pkg.sv
      - player_cmd_if.sv
      - pace_timer.sv
      - round_sequencer.sv
      - player_turn.sv
      - datapath_port_mux.sv
      - game_control.sv
  - target: test
    files:
      - game_control_assertions.sv
      - game_control_tb.sv
